//--- hw/cache_pkg.sv
package cache_pkg;

    ////////////////////////////////////////
    // Bus and line geometry
    ////////////////////////////////////////

    localparam int ADDR_WIDTH   = 32;
    localparam int WORD_WIDTH   = 64;
    localparam int LINE_BYTES   = 32;
    localparam int LINE_WIDTH   = LINE_BYTES * 8;
    localparam int OFFSET_WIDTH = $clog2(LINE_BYTES);

    ////////////////////////////////////////
    // Encodings
    ////////////////////////////////////////

    // Store size, 1 << len bytes
    typedef enum logic [1:0] {
        LEN_BYTE,
        LEN_HALF,
        LEN_WORD,
        LEN_DOUBLE
    } access_len_e;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_LOOKUP,
        ST_MISS,
        ST_REPLACE,
        ST_REFILL,
        ST_WRITE,
        ST_SWEEP
    } cache_state_e;

endpackage

//--- hw/sweep_counter.sv
`timescale 1ns/100ps

module sweep_counter #(
    parameter int INDEX_WIDTH = 6
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   en,
    output logic [INDEX_WIDTH-1:0] sweep_index,
    output logic                   last
);

    // Restarts from set 0 every time a sweep begins
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sweep_index <= '0;
        end else if (en) begin
            sweep_index <= sweep_index + 1'b1;
        end else begin
            sweep_index <= '0;
        end
    end

    assign last = en && (&sweep_index);

endmodule

//--- hw/tag_way.sv
`timescale 1ns/100ps

module tag_way
    import cache_pkg::*;
#(
    parameter int  INDEX_WIDTH = 6,
    localparam int TAG_WIDTH   = ADDR_WIDTH - INDEX_WIDTH - OFFSET_WIDTH
) (
    input  logic                   clk,
    input  logic                   en,
    input  logic                   we,
    input  logic [INDEX_WIDTH-1:0] index,
    input  logic [TAG_WIDTH-1:0]   wr_tag,
    input  logic                   wr_valid,
    input  logic                   wr_dirty,
    input  logic [TAG_WIDTH-1:0]   lookup_tag,
    output logic                   hit,
    output logic [TAG_WIDTH-1:0]   rd_tag,
    output logic                   rd_dirty
);

    // Entry layout is dirty, valid, tag
    logic [TAG_WIDTH+1:0] entries [2**INDEX_WIDTH];
    logic                 rd_valid;

    // Read returns the entry as it was before a same-cycle write
    always_ff @(posedge clk) begin
        if (en) begin
            if (we) begin
                entries[index] <= {wr_dirty, wr_valid, wr_tag};
            end
            {rd_dirty, rd_valid, rd_tag} <= entries[index];
        end
    end

    assign hit = rd_valid && (rd_tag == lookup_tag);

endmodule

//--- hw/data_way.sv
`timescale 1ns/100ps

module data_way
    import cache_pkg::*;
#(
    parameter int INDEX_WIDTH = 6
) (
    input  logic                   clk,
    input  logic                   en,
    input  logic                   we,
    input  logic [INDEX_WIDTH-1:0] index,
    input  logic [LINE_WIDTH-1:0]  wr_line,
    output logic [LINE_WIDTH-1:0]  rd_line
);

    logic [LINE_WIDTH-1:0] lines [2**INDEX_WIDTH];

    // Whole-line writes only, store bytes are merged upstream
    always_ff @(posedge clk) begin
        if (en) begin
            if (we) begin
                lines[index] <= wr_line;
            end
            rd_line <= lines[index];
        end
    end

    assert property (@(posedge clk) en |-> !$isunknown(index));

endmodule

//--- hw/request_datapath.sv
`timescale 1ns/100ps

module request_datapath
    import cache_pkg::*;
#(
    parameter int  INDEX_WIDTH = 6,
    localparam int TAG_WIDTH   = ADDR_WIDTH - INDEX_WIDTH - OFFSET_WIDTH
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   capture,
    input  logic                   sweep_en,
    input  logic                   fill_from_mem,
    input  logic                   victim_way,
    input  logic                   hit_way,
    input  logic [ADDR_WIDTH-1:0]  addr,
    input  logic [WORD_WIDTH-1:0]  data_in,
    input  logic [1:0]             len,
    input  logic                   write,
    input  logic [LINE_WIDTH-1:0]  line0,
    input  logic [LINE_WIDTH-1:0]  line1,
    input  logic [LINE_WIDTH-1:0]  re_data,
    input  logic [INDEX_WIDTH-1:0] sweep_index,
    input  logic [TAG_WIDTH-1:0]   victim_tag0,
    input  logic [TAG_WIDTH-1:0]   victim_tag1,
    output logic [INDEX_WIDTH-1:0] array_index,
    output logic [TAG_WIDTH-1:0]   req_tag,
    output logic                   req_write,
    output logic [LINE_WIDTH-1:0]  merged_line,
    output logic [WORD_WIDTH-1:0]  data_out,
    output logic [ADDR_WIDTH-1:0]  r_addr,
    output logic [ADDR_WIDTH-1:0]  w_addr,
    output logic [LINE_WIDTH-1:0]  w_data
);

    logic [INDEX_WIDTH-1:0]  req_index;
    logic [OFFSET_WIDTH-1:0] req_offset;
    logic [WORD_WIDTH-1:0]   req_data;
    access_len_e             req_len;
    logic [LINE_WIDTH-1:0]   base_line;
    logic [LINE_WIDTH-1:0]   shifted_line;
    logic [LINE_WIDTH-1:0]   len_mask;
    logic [LINE_WIDTH-1:0]   store_mask;
    logic [LINE_WIDTH-1:0]   store_line;
    logic [TAG_WIDTH-1:0]    victim_tag;

    ////////////////////////////////////////
    // Request register
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            req_write <= 1'b0;
        end else if (capture) begin
            req_write <= write;
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            req_tag    <= addr[ADDR_WIDTH-1 -: TAG_WIDTH];
            req_index  <= addr[OFFSET_WIDTH +: INDEX_WIDTH];
            req_offset <= addr[OFFSET_WIDTH-1:0];
            req_data   <= data_in;
            req_len    <= access_len_e'(len);
        end
    end

    // New request index while capturing, so the arrays read it at once
    assign array_index = capture  ? addr[OFFSET_WIDTH +: INDEX_WIDTH] :
                         sweep_en ? sweep_index : req_index;

    ////////////////////////////////////////
    // Load extraction and store merge
    ////////////////////////////////////////

    assign base_line    = fill_from_mem ? re_data : (hit_way ? line1 : line0);
    assign shifted_line = base_line >> {req_offset, 3'b000};
    assign data_out     = shifted_line[WORD_WIDTH-1:0];

    always_comb begin
        case (req_len)
            LEN_BYTE:   len_mask = LINE_WIDTH'({8{1'b1}});
            LEN_HALF:   len_mask = LINE_WIDTH'({16{1'b1}});
            LEN_WORD:   len_mask = LINE_WIDTH'({32{1'b1}});
            LEN_DOUBLE: len_mask = LINE_WIDTH'({WORD_WIDTH{1'b1}});
        endcase
    end

    // Bytes shifted past the line end fall off, which clips the store
    assign store_mask  = len_mask << {req_offset, 3'b000};
    assign store_line  = LINE_WIDTH'(req_data) << {req_offset, 3'b000};
    assign merged_line = req_write ? ((base_line & ~store_mask) | (store_line & store_mask))
                                   : base_line;

    ////////////////////////////////////////
    // Memory side addresses
    ////////////////////////////////////////

    assign victim_tag = victim_way ? victim_tag1 : victim_tag0;

    assign r_addr = {req_tag, req_index, {OFFSET_WIDTH{1'b0}}};
    assign w_addr = {victim_tag, req_index, {OFFSET_WIDTH{1'b0}}};
    assign w_data = victim_way ? line1 : line0;

endmodule

//--- hw/cache_fsm.sv
`timescale 1ns/100ps

module cache_fsm
    import cache_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  logic         valid_in,
    input  logic         fence_i,
    input  logic         req_write,
    input  logic         hit0,
    input  logic         hit1,
    input  logic         victim_dirty,
    input  logic         w_rdy,
    input  logic         r_rdy,
    input  logic         re_valid,
    input  logic         sweep_last,
    output cache_state_e state,
    output logic         addr_ok,
    output logic         data_ok,
    output logic         capture,
    output logic         array_en,
    output logic         sweep_en,
    output logic         fill_from_mem,
    output logic         victim_way,
    output logic         hit_way,
    output logic         tag_we0,
    output logic         tag_we1,
    output logic         tag_wr_valid,
    output logic         data_we0,
    output logic         data_we1,
    output logic         r_req,
    output logic         w_req
);

    cache_state_e next_state;
    logic         hit;
    logic         load_hit;
    logic         store_hit_write;
    logic         fill_done;

    ////////////////////////////////////////
    // State register
    ////////////////////////////////////////

    // Leaving reset runs one full invalidation sweep
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ST_SWEEP;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            ST_IDLE: begin
                if (valid_in) begin
                    next_state = ST_LOOKUP;
                end else if (fence_i) begin
                    next_state = ST_SWEEP;
                end
            end
            ST_LOOKUP: begin
                if (!hit) begin
                    next_state = ST_MISS;
                end else if (req_write) begin
                    next_state = ST_WRITE;
                end else if (!valid_in) begin
                    next_state = ST_IDLE;
                end
            end
            // Clean victims skip the write-back
            ST_MISS: begin
                if (!victim_dirty || w_rdy) begin
                    next_state = ST_REPLACE;
                end
            end
            ST_REPLACE: begin
                if (r_rdy) begin
                    next_state = ST_REFILL;
                end
            end
            ST_REFILL: begin
                if (re_valid) begin
                    next_state = ST_IDLE;
                end
            end
            ST_WRITE: next_state = ST_IDLE;
            ST_SWEEP: begin
                if (sweep_last) begin
                    next_state = ST_IDLE;
                end
            end
            default: next_state = ST_IDLE;
        endcase
    end

    // Replacement way flips on every lookup
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            victim_way <= 1'b0;
        end else if (state == ST_LOOKUP) begin
            victim_way <= ~victim_way;
        end
    end

    ////////////////////////////////////////
    // Handshakes and array strobes
    ////////////////////////////////////////

    assign hit       = hit0 | hit1;
    assign hit_way   = hit1;
    assign load_hit  = (state == ST_LOOKUP) && hit && !req_write;
    assign fill_done = (state == ST_REFILL) && re_valid;

    // Tag outputs still hold the lookup result in ST_WRITE
    assign store_hit_write = (state == ST_WRITE);

    assign addr_ok = (state == ST_IDLE) || load_hit;
    assign capture = valid_in && addr_ok;
    assign data_ok = load_hit || store_hit_write || fill_done;

    assign sweep_en      = (state == ST_SWEEP);
    assign fill_from_mem = (state == ST_REFILL);
    assign array_en      = capture || sweep_en || store_hit_write || fill_done;

    assign data_we0 = (store_hit_write && hit0) || (fill_done && !victim_way);
    assign data_we1 = (store_hit_write && hit1) || (fill_done && victim_way);

    // Sweep clears both ways at once
    assign tag_we0      = sweep_en || data_we0;
    assign tag_we1      = sweep_en || data_we1;
    assign tag_wr_valid = !sweep_en;

    assign w_req = (state == ST_MISS) && victim_dirty;
    assign r_req = (state == ST_REPLACE);

    assert property (@(posedge clk) disable iff (!rst_n)
        w_req && !w_rdy |=> w_req);

    // A line is never cached in both ways
    assert property (@(posedge clk) disable iff (!rst_n)
        state == ST_LOOKUP |-> !(hit0 && hit1));

endmodule

//--- hw/cache_top.sv
`timescale 1ns/100ps

module cache_top
    import cache_pkg::*;
#(
    parameter int  INDEX_WIDTH = 6,
    localparam int TAG_WIDTH   = ADDR_WIDTH - INDEX_WIDTH - OFFSET_WIDTH
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  valid_in,
    input  logic [ADDR_WIDTH-1:0] addr,
    input  logic [WORD_WIDTH-1:0] data_in,
    input  logic [1:0]            len,
    input  logic                  write,
    input  logic                  fence_i,
    output logic                  addr_ok,
    output logic                  data_ok,
    output logic [WORD_WIDTH-1:0] data_out,
    output logic                  r_req,
    output logic [ADDR_WIDTH-1:0] r_addr,
    input  logic                  r_rdy,
    input  logic [LINE_WIDTH-1:0] re_data,
    input  logic                  re_valid,
    output logic                  w_req,
    output logic [ADDR_WIDTH-1:0] w_addr,
    output logic [LINE_WIDTH-1:0] w_data,
    input  logic                  w_rdy
);

    cache_state_e           state;
    logic                   capture;
    logic                   array_en;
    logic                   sweep_en;
    logic                   sweep_last;
    logic                   fill_from_mem;
    logic                   victim_way;
    logic                   victim_dirty;
    logic                   hit_way;
    logic                   hit0;
    logic                   hit1;
    logic                   tag_we0;
    logic                   tag_we1;
    logic                   tag_wr_valid;
    logic                   tag_wr_dirty;
    logic                   data_we0;
    logic                   data_we1;
    logic                   req_write;
    logic [INDEX_WIDTH-1:0] sweep_index;
    logic [INDEX_WIDTH-1:0] array_index;
    logic [TAG_WIDTH-1:0]   req_tag;
    logic [TAG_WIDTH-1:0]   rd_tag0;
    logic [TAG_WIDTH-1:0]   rd_tag1;
    logic                   rd_dirty0;
    logic                   rd_dirty1;
    logic [LINE_WIDTH-1:0]  line0;
    logic [LINE_WIDTH-1:0]  line1;
    logic [LINE_WIDTH-1:0]  merged_line;

    assign victim_dirty = victim_way ? rd_dirty1 : rd_dirty0;

    // Store hits always dirty the line, refills only for a store miss
    assign tag_wr_dirty = (state == ST_WRITE) || ((state == ST_REFILL) && req_write);

    ////////////////////////////////////////
    // Control
    ////////////////////////////////////////

    cache_fsm fsm_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .valid_in      (valid_in),
        .fence_i       (fence_i),
        .req_write     (req_write),
        .hit0          (hit0),
        .hit1          (hit1),
        .victim_dirty  (victim_dirty),
        .w_rdy         (w_rdy),
        .r_rdy         (r_rdy),
        .re_valid      (re_valid),
        .sweep_last    (sweep_last),
        .state         (state),
        .addr_ok       (addr_ok),
        .data_ok       (data_ok),
        .capture       (capture),
        .array_en      (array_en),
        .sweep_en      (sweep_en),
        .fill_from_mem (fill_from_mem),
        .victim_way    (victim_way),
        .hit_way       (hit_way),
        .tag_we0       (tag_we0),
        .tag_we1       (tag_we1),
        .tag_wr_valid  (tag_wr_valid),
        .data_we0      (data_we0),
        .data_we1      (data_we1),
        .r_req         (r_req),
        .w_req         (w_req)
    );

    sweep_counter #(.INDEX_WIDTH(INDEX_WIDTH)) sweep_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .en          (sweep_en),
        .sweep_index (sweep_index),
        .last        (sweep_last)
    );

    ////////////////////////////////////////
    // Storage, one tag and one data array per way
    ////////////////////////////////////////

    tag_way #(.INDEX_WIDTH(INDEX_WIDTH)) tag0_i (
        .clk        (clk),
        .en         (array_en),
        .we         (tag_we0),
        .index      (array_index),
        .wr_tag     (req_tag),
        .wr_valid   (tag_wr_valid),
        .wr_dirty   (tag_wr_dirty),
        .lookup_tag (req_tag),
        .hit        (hit0),
        .rd_tag     (rd_tag0),
        .rd_dirty   (rd_dirty0)
    );

    tag_way #(.INDEX_WIDTH(INDEX_WIDTH)) tag1_i (
        .clk        (clk),
        .en         (array_en),
        .we         (tag_we1),
        .index      (array_index),
        .wr_tag     (req_tag),
        .wr_valid   (tag_wr_valid),
        .wr_dirty   (tag_wr_dirty),
        .lookup_tag (req_tag),
        .hit        (hit1),
        .rd_tag     (rd_tag1),
        .rd_dirty   (rd_dirty1)
    );

    data_way #(.INDEX_WIDTH(INDEX_WIDTH)) data0_i (
        .clk     (clk),
        .en      (array_en),
        .we      (data_we0),
        .index   (array_index),
        .wr_line (merged_line),
        .rd_line (line0)
    );

    data_way #(.INDEX_WIDTH(INDEX_WIDTH)) data1_i (
        .clk     (clk),
        .en      (array_en),
        .we      (data_we1),
        .index   (array_index),
        .wr_line (merged_line),
        .rd_line (line1)
    );

    request_datapath #(.INDEX_WIDTH(INDEX_WIDTH)) datapath_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .capture       (capture),
        .sweep_en      (sweep_en),
        .fill_from_mem (fill_from_mem),
        .victim_way    (victim_way),
        .hit_way       (hit_way),
        .addr          (addr),
        .data_in       (data_in),
        .len           (len),
        .write         (write),
        .line0         (line0),
        .line1         (line1),
        .re_data       (re_data),
        .sweep_index   (sweep_index),
        .victim_tag0   (rd_tag0),
        .victim_tag1   (rd_tag1),
        .array_index   (array_index),
        .req_tag       (req_tag),
        .req_write     (req_write),
        .merged_line   (merged_line),
        .data_out      (data_out),
        .r_addr        (r_addr),
        .w_addr        (w_addr),
        .w_data        (w_data)
    );

endmodule

//--- tb/cache_tb.sv
`timescale 1ns/100ps

module cache_tb;

    import cache_pkg::*;

    localparam int CYCLE_LIMIT = 20000;
    localparam int SWEEP_CYCLES = 64;

    logic                  clk;
    logic                  rst_n;
    logic                  valid_in;
    logic [ADDR_WIDTH-1:0] addr;
    logic [WORD_WIDTH-1:0] data_in;
    logic [1:0]            len;
    logic                  write;
    logic                  fence_i;
    logic                  addr_ok;
    logic                  data_ok;
    logic [WORD_WIDTH-1:0] data_out;
    logic                  r_req;
    logic [ADDR_WIDTH-1:0] r_addr;
    logic                  r_rdy;
    logic [LINE_WIDTH-1:0] re_data;
    logic                  re_valid;
    logic                  w_req;
    logic [ADDR_WIDTH-1:0] w_addr;
    logic [LINE_WIDTH-1:0] w_data;
    logic                  w_rdy;

    // Memory contents and the processor's view of every byte
    logic [LINE_WIDTH-1:0] mem [logic [31:0]];
    logic [7:0]            shadow [logic [31:0]];

    logic [WORD_WIDTH-1:0] exp_q [$];
    bit                    load_q [$];
    int                    acc_q [$];
    int                    lat_q [$];

    logic [31:0] lfsr_state;
    logic [31:0] last_r_addr;
    logic [31:0] last_w_addr;
    int          cycles;
    int          errors;
    int          checks;
    int          issued;
    int          resp_count;
    int          accept_count;
    int          r_count;
    int          w_count;

    cache_top #(.INDEX_WIDTH(6)) dut_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .valid_in (valid_in),
        .addr     (addr),
        .data_in  (data_in),
        .len      (len),
        .write    (write),
        .fence_i  (fence_i),
        .addr_ok  (addr_ok),
        .data_ok  (data_ok),
        .data_out (data_out),
        .r_req    (r_req),
        .r_addr   (r_addr),
        .r_rdy    (r_rdy),
        .re_data  (re_data),
        .re_valid (re_valid),
        .w_req    (w_req),
        .w_addr   (w_addr),
        .w_data   (w_data),
        .w_rdy    (w_rdy)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles == CYCLE_LIMIT) begin
            $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Something failed");
            $finish;
        end
    end

    ////////////////////////////////////////
    // Random numbers and reference model
    ////////////////////////////////////////

    function automatic logic random_bit();
        if (lfsr_state[0]) begin
            lfsr_state = (lfsr_state >> 1) ^ 32'h8020_0003;
        end else begin
            lfsr_state = lfsr_state >> 1;
        end
        return lfsr_state[0];
    endfunction

    function automatic logic [63:0] random_bits(int n);
        logic [63:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[62:0], random_bit()};
        end
        return r;
    endfunction

    // Unwritten lines read as the folded line address plus byte number
    function automatic logic [7:0] memory_byte(logic [31:0] a);
        logic [31:0] la;
        la = {a[31:5], 5'b00000};
        if (mem.exists(la)) begin
            return mem[la][{a[4:0], 3'b000} +: 8];
        end
        return (la[31:24] ^ la[23:16] ^ la[15:8] ^ la[7:0]) + {3'b000, a[4:0]};
    endfunction

    function automatic logic [7:0] shadow_byte(logic [31:0] a);
        if (shadow.exists(a)) begin
            return shadow[a];
        end
        return memory_byte(a);
    endfunction

    function automatic logic [LINE_WIDTH-1:0] memory_line(logic [31:0] la);
        logic [LINE_WIDTH-1:0] l;
        for (int i = 0; i < LINE_BYTES; i++) begin
            l[i*8 +: 8] = memory_byte(la + 32'(i));
        end
        return l;
    endfunction

    function automatic logic [LINE_WIDTH-1:0] shadow_line(logic [31:0] la);
        logic [LINE_WIDTH-1:0] l;
        for (int i = 0; i < LINE_BYTES; i++) begin
            l[i*8 +: 8] = shadow_byte(la + 32'(i));
        end
        return l;
    endfunction

    // Little-endian, bytes past the line end are zero
    function automatic logic [63:0] expected_load(logic [31:0] a);
        logic [63:0] w;
        int          off;
        w = '0;
        off = int'(a[4:0]);
        for (int i = 0; i < 8; i++) begin
            if (off + i < LINE_BYTES) begin
                w[i*8 +: 8] = shadow_byte(a + 32'(i));
            end
        end
        return w;
    endfunction

    function automatic void apply_store(logic [31:0] a, logic [1:0] ln, logic [63:0] d);
        int off;
        int n;
        off = int'(a[4:0]);
        n = 1 << ln;
        for (int i = 0; i < n; i++) begin
            if (off + i < LINE_BYTES) begin
                shadow[a + 32'(i)] = d[i*8 +: 8];
            end
        end
    endfunction

    ////////////////////////////////////////
    // Memory model with random back-pressure
    ////////////////////////////////////////

    initial begin
        logic [31:0] la;
        r_rdy = 1'b0;
        w_rdy = 1'b0;
        re_valid = 1'b0;
        re_data = '0;
        forever begin
            @(posedge clk);
            #1;
            if (w_req) begin
                repeat (int'(random_bits(2))) begin
                    @(posedge clk);
                    #1;
                end
                w_rdy = 1'b1;
                checks++;
                if (w_data !== shadow_line(w_addr)) begin
                    errors++;
                    $display("FAILED at %0t: write-back data for line %h", $time, w_addr);
                end
                mem[w_addr] = w_data;
                last_w_addr = w_addr;
                w_count++;
                @(posedge clk);
                #1;
                w_rdy = 1'b0;
            end else if (r_req) begin
                repeat (int'(random_bits(2))) begin
                    @(posedge clk);
                    #1;
                end
                r_rdy = 1'b1;
                la = r_addr;
                last_r_addr = r_addr;
                r_count++;
                @(posedge clk);
                #1;
                r_rdy = 1'b0;
                repeat (int'(random_bits(2))) begin
                    @(posedge clk);
                    #1;
                end
                re_data = memory_line(la);
                re_valid = 1'b1;
                @(posedge clk);
                #1;
                re_valid = 1'b0;
            end
        end
    end

    ////////////////////////////////////////
    // Processor side driver and response monitor
    ////////////////////////////////////////

    always @(negedge clk) begin
        logic [63:0] e;
        bit          ld;
        int          ac;
        if (rst_n && valid_in && addr_ok) begin
            accept_count++;
        end
        if (rst_n && data_ok) begin
            resp_count++;
            if (exp_q.size() == 0) begin
                errors++;
                $display("A data_ok pulse arrived with no request outstanding");
            end else begin
                e = exp_q.pop_front();
                ld = load_q.pop_front();
                ac = acc_q.pop_front();
                lat_q.push_back(cycles - ac);
                checks++;
                if (ld && data_out !== e) begin
                    errors++;
                    $display("FAILED at %0t: load data %h, expected %h", $time, data_out, e);
                end
            end
        end
    end

    task automatic send_request(logic [31:0] a, logic wr, logic [1:0] ln, logic [63:0] d);
        logic ok;
        int   accepted_at;
        valid_in = 1'b1;
        addr = a;
        write = wr;
        len = ln;
        data_in = d;
        ok = 1'b0;
        accepted_at = 0;
        while (!ok) begin
            @(negedge clk);
            ok = addr_ok;
            accepted_at = cycles;
            @(posedge clk);
            #1;
        end
        exp_q.push_back(wr ? 64'h0 : expected_load(a));
        load_q.push_back(!wr);
        acc_q.push_back(accepted_at);
        if (wr) begin
            apply_store(a, ln, d);
        end
        issued++;
        valid_in = 1'b0;
    endtask

    task automatic wait_responses();
        while (resp_count < issued) begin
            @(posedge clk);
            #1;
        end
        @(posedge clk);
        #1;
    endtask

    // Counts cycles with addr_ok low, starting in the current cycle
    task automatic count_blocked(output int cnt);
        cnt = 0;
        @(negedge clk);
        while (!addr_ok) begin
            cnt++;
            @(negedge clk);
        end
        @(posedge clk);
        #1;
    endtask

    ////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////

    task automatic test_reset_sweep();
        int cnt;
        count_blocked(cnt);
        checks++;
        if (cnt != SWEEP_CYCLES) begin
            errors++;
            $display("FAILED at %0t: addr_ok low for %0d cycles after reset", $time, cnt);
        end
        send_request(32'h1000_0048, 1'b0, 2'd3, 64'h0);
        wait_responses();
        checks++;
        if (r_count != 1 || last_r_addr !== 32'h1000_0040) begin
            errors++;
            $display("FAILED at %0t: refill address %h, count %0d", $time, last_r_addr, r_count);
        end
        $display("test reset_sweep finished, errors %0d", errors);
    endtask

    task automatic test_load_hits();
        int reads;
        send_request(32'h1000_0060, 1'b0, 2'd3, 64'h0);
        wait_responses();
        reads = r_count;
        send_request(32'h1000_0060, 1'b0, 2'd3, 64'h0);
        send_request(32'h1000_0068, 1'b0, 2'd3, 64'h0);
        send_request(32'h1000_007b, 1'b0, 2'd3, 64'h0);
        wait_responses();
        checks++;
        if (r_count != reads) begin
            errors++;
            $display("FAILED at %0t: load hits raised %0d extra refill requests",
                     $time, r_count - reads);
        end
        for (int i = 1; i <= 3; i++) begin
            checks++;
            if (lat_q[lat_q.size() - i] != 1) begin
                errors++;
                $display("FAILED at %0t: hit latency %0d", $time, lat_q[lat_q.size() - i]);
            end
        end
        $display("test load_hits finished, errors %0d", errors);
    endtask

    task automatic test_store_sizes();
        int offs [7] = '{0, 9, 14, 20, 27, 30, 31};
        int lens [7] = '{3, 0, 1, 2, 3, 2, 1};
        int rd [6] = '{0, 8, 16, 24, 28, 31};
        for (int i = 0; i < 7; i++) begin
            send_request(32'h2000_0100 + 32'(offs[i]), 1'b1, 2'(lens[i]), random_bits(64));
        end
        // Store misses, one clipped at the line end
        send_request(32'h2000_013d, 1'b1, 2'd3, random_bits(64));
        send_request(32'h2000_015f, 1'b1, 2'd0, random_bits(64));
        for (int i = 0; i < 6; i++) begin
            send_request(32'h2000_0100 + 32'(rd[i]), 1'b0, 2'd3, 64'h0);
        end
        send_request(32'h2000_0138, 1'b0, 2'd3, 64'h0);
        send_request(32'h2000_013d, 1'b0, 2'd3, 64'h0);
        send_request(32'h2000_015f, 1'b0, 2'd3, 64'h0);
        wait_responses();
        $display("test store_sizes finished, errors %0d", errors);
    endtask

    task automatic test_eviction();
        int writes;
        writes = w_count;
        send_request(32'h3000_0204, 1'b1, 2'd3, random_bits(64));
        send_request(32'h3100_0210, 1'b1, 2'd2, random_bits(64));
        send_request(32'h3200_0200, 1'b0, 2'd3, 64'h0);
        wait_responses();
        checks++;
        if (w_count != writes + 1) begin
            errors++;
            $display("FAILED at %0t: %0d write-backs on eviction", $time, w_count - writes);
        end
        checks++;
        if (last_w_addr !== 32'h3000_0200 && last_w_addr !== 32'h3100_0200) begin
            errors++;
            $display("FAILED at %0t: write-back address %h", $time, last_w_addr);
        end
        send_request(32'h3000_0204, 1'b0, 2'd3, 64'h0);
        send_request(32'h3100_0210, 1'b0, 2'd3, 64'h0);
        wait_responses();
        $display("test eviction finished, errors %0d", errors);
    endtask

    task automatic test_fence();
        int cnt;
        int reads;
        send_request(32'h4000_0300, 1'b0, 2'd3, 64'h0);
        send_request(32'h4000_0308, 1'b0, 2'd3, 64'h0);
        wait_responses();
        fence_i = 1'b1;
        @(posedge clk);
        #1;
        fence_i = 1'b0;
        // Dirty lines are dropped, so memory is the processor view again
        shadow.delete();
        count_blocked(cnt);
        checks++;
        if (cnt != SWEEP_CYCLES) begin
            errors++;
            $display("FAILED at %0t: addr_ok low for %0d cycles after fence", $time, cnt);
        end
        reads = r_count;
        send_request(32'h4000_0300, 1'b0, 2'd3, 64'h0);
        wait_responses();
        checks++;
        if (r_count != reads + 1 || last_r_addr !== 32'h4000_0300) begin
            errors++;
            $display("FAILED at %0t: reload after fence, refill %h", $time, last_r_addr);
        end
        $display("test fence finished, errors %0d", errors);
    endtask

    task automatic test_random_mix();
        logic [31:0] a;
        logic        wr;
        logic [1:0]  ln;
        for (int i = 0; i < 200; i++) begin
            a = 32'h5000_0000 | (32'(random_bits(2)) << 12) | (32'(random_bits(2)) << 5);
            a = a | 32'(random_bits(5));
            wr = random_bit();
            ln = 2'(random_bits(2));
            send_request(a, wr, ln, random_bits(64));
        end
        wait_responses();
        repeat (10) @(posedge clk);
        #1;
        checks++;
        if (resp_count != accept_count || exp_q.size() != 0) begin
            errors++;
            $display("FAILED at %0t: %0d responses for %0d accepted requests",
                     $time, resp_count, accept_count);
        end
        $display("test random_mix finished, errors %0d", errors);
    endtask

    initial begin
        lfsr_state = 32'hdd35;
        cycles = 0;
        errors = 0;
        checks = 0;
        issued = 0;
        resp_count = 0;
        accept_count = 0;
        r_count = 0;
        w_count = 0;
        last_r_addr = '0;
        last_w_addr = '0;
        rst_n = 1'b0;
        valid_in = 1'b0;
        addr = '0;
        data_in = '0;
        len = 2'd0;
        write = 1'b0;
        fence_i = 1'b0;
        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;

        test_reset_sweep();
        test_load_hits();
        test_store_sizes();
        test_eviction();
        test_fence();
        test_random_mix();

        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

//--- all.f
hw/cache_pkg.sv
hw/sweep_counter.sv
hw/tag_way.sv
hw/data_way.sv
hw/request_datapath.sv
hw/cache_fsm.sv
hw/cache_top.sv
tb/cache_tb.sv

//--- Makefile
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f all.f --top-module cache_tb -Mdir obj_dir

run: compile
	@out="$$(./obj_dir/Vcache_tb)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Everything OK"

clean:
	rm -rf obj_dir
